/* fib_defs.svh */
`ifndef FIB_DEFS_SVH
`define FIB_DEFS_SVH

// Full NDN name carried in every interest
`define FIB_NAME_BITS 64
`define FIB_NAME_BYTES 8

// Prefix length field, 0 means no route
`define FIB_LEN_BITS 6

// Bank index width, 1024 route bits per prefix length
`define FIB_HASH_BITS 10

// Credits granted by the SPI transmitter out of reset
`define FIB_SPI_CREDITS 4

`endif

/* ndn_pkg.sv */
`include "fib_defs.svh"

package ndn_pkg;

    // Name as seen on the wire, first byte in the top bits
    typedef logic [`FIB_NAME_BITS-1:0] name_t;

    // Prefix length in bits
    typedef logic [`FIB_LEN_BITS-1:0] len_t;

    // Metadata byte of an interest
    // Flags on top, requested prefix length below
    typedef struct packed {
        logic [1:0] flags;
        len_t       len;
    } meta_t;

endpackage

/* fib_pkg.sv */
`include "fib_defs.svh"

package fib_pkg;

    // Bit index inside one route bank
    typedef logic [`FIB_HASH_BITS-1:0] hash_t;

    // Interest receiver
    typedef enum logic {
        RX_IDLE,
        RX_NAME
    } rx_state_e;

    // Longest-prefix-match engine
    typedef enum logic [1:0] {
        LPM_IDLE,
        LPM_HASH,
        LPM_PROBE,
        LPM_DONE
    } lpm_state_e;

    // Segment of the outgoing 17-byte stream
    typedef enum logic [1:0] {
        SEG_META,
        SEG_NAME,
        SEG_MATCH
    } tx_seg_e;

endpackage

/* fib_tx_if.sv */
`timescale 1ns/10ps
`include "fib_defs.svh"

interface fib_tx_if;

    // Result offer from the match engine
    logic          valid;
    logic          ready;
    ndn_pkg::meta_t meta;
    ndn_pkg::name_t name;
    // Masked name at the found length, zero on a miss
    ndn_pkg::name_t match;

    modport engine (output valid, output meta, output name, output match, input ready);

    modport tx (input valid, input meta, input name, input match, output ready);

endinterface

/* fib_name_hash.sv */
`timescale 1ns/10ps
`include "fib_defs.svh"

module fib_name_hash (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    input  ndn_pkg::name_t in_name,
    input  ndn_pkg::len_t  in_len,
    output logic           out_valid,
    output ndn_pkg::name_t out_masked,
    output ndn_pkg::len_t  out_len,
    output fib_pkg::hash_t out_index
);

    ndn_pkg::name_t masked_c;
    fib_pkg::hash_t index_c;

    always_comb begin
        // Keep top in_len bits, length 0 clears everything
        masked_c = in_name & ~({`FIB_NAME_BITS{1'b1}} >> in_len);
        // XOR fold in 10-bit chunks from bit 0, last chunk short
        index_c = '0;
        for (int i = 0; i < `FIB_NAME_BITS; i++) begin
            index_c[i % `FIB_HASH_BITS] = index_c[i % `FIB_HASH_BITS] ^ masked_c[i];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Result lines follow the input one clock later
    always_ff @(posedge clk) begin
        out_masked <= masked_c;
        out_len    <= in_len;
        out_index  <= index_c;
    end

endmodule

/* fib_route_table.sv */
`timescale 1ns/10ps
`include "fib_defs.svh"

module fib_route_table (
    input  logic           clk,
    input  logic           rst,
    input  logic           route_wr,
    input  logic           route_remove,
    input  ndn_pkg::len_t  route_len,
    input  ndn_pkg::name_t route_name,
    input  ndn_pkg::len_t  probe_len,
    input  fib_pkg::hash_t probe_index,
    output logic           probe_hit
);

    localparam int BANK_BITS = 1 << `FIB_HASH_BITS;
    localparam int NUM_BANKS = 1 << `FIB_LEN_BITS;

    // One bit bank per prefix length
    logic [BANK_BITS-1:0] bank [NUM_BANKS];

    logic           wr_valid;
    ndn_pkg::len_t  wr_len;
    fib_pkg::hash_t wr_index;
    logic           remove_q;

    // Hash cycle of an install or withdraw
    fib_name_hash wr_hash_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (route_wr),
        .in_name    (route_name),
        .in_len     (route_len),
        .out_valid  (wr_valid),
        .out_masked (),
        .out_len    (wr_len),
        .out_index  (wr_index)
    );

    // Operation travels alongside the hash
    always_ff @(posedge clk) begin
        remove_q <= route_remove;
    end

    // Write cycle, length 0 never holds a route
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_BANKS; i++) begin
                bank[i] <= '0;
            end
        end else if (wr_valid && wr_len != '0) begin
            bank[wr_len][wr_index] <= !remove_q;
        end
    end

    // Same-cycle probe read
    assign probe_hit = bank[probe_len][probe_index];

endmodule

/* fib_interest_rx.sv */
`timescale 1ns/10ps
`include "fib_defs.svh"

module fib_interest_rx (
    input  logic           clk,
    input  logic           rst,
    input  logic           rx_valid,
    input  logic [7:0]     rx_data,
    output logic           pit_req_valid,
    output ndn_pkg::meta_t pit_req_meta,
    output ndn_pkg::name_t pit_req_name
);

    localparam int CNT_BITS = $clog2(`FIB_NAME_BYTES);
    localparam logic [CNT_BITS-1:0] LAST_BYTE = CNT_BITS'(`FIB_NAME_BYTES - 1);

    fib_pkg::rx_state_e  state;
    logic [CNT_BITS-1:0] byte_cnt;
    ndn_pkg::meta_t      meta_q;
    ndn_pkg::name_t      name_sr;
    logic                name_done;

    assign name_done = rx_valid && state == fib_pkg::RX_NAME && byte_cnt == LAST_BYTE;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= fib_pkg::RX_IDLE;
            byte_cnt      <= '0;
            pit_req_valid <= 1'b0;
        end else begin
            // Single-cycle pulse toward the PIT
            pit_req_valid <= name_done;
            if (rx_valid) begin
                case (state)
                    fib_pkg::RX_IDLE: begin
                        // Metadata byte opens the packet
                        state    <= fib_pkg::RX_NAME;
                        byte_cnt <= '0;
                    end
                    default: begin
                        if (byte_cnt == LAST_BYTE) begin
                            state <= fib_pkg::RX_IDLE;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && state == fib_pkg::RX_IDLE) begin
            meta_q <= ndn_pkg::meta_t'(rx_data);
        end
        // Name arrives most significant byte first
        if (rx_valid && state == fib_pkg::RX_NAME) begin
            name_sr <= {name_sr[`FIB_NAME_BITS-9:0], rx_data};
        end
        // Published copy holds until the next packet completes
        if (name_done) begin
            pit_req_meta <= meta_q;
            pit_req_name <= {name_sr[`FIB_NAME_BITS-9:0], rx_data};
        end
    end

endmodule

/* fib_lpm_engine.sv */
`timescale 1ns/10ps
`include "fib_defs.svh"

module fib_lpm_engine (
    input  logic           clk,
    input  logic           rst,
    input  logic           lookup_valid,
    input  ndn_pkg::meta_t lookup_meta,
    input  ndn_pkg::name_t lookup_name,
    output logic           lookup_ready,
    output ndn_pkg::len_t  probe_len,
    output fib_pkg::hash_t probe_index,
    input  logic           probe_hit,
    fib_tx_if.engine       tx
);

    fib_pkg::lpm_state_e state;
    ndn_pkg::len_t       cur_len;
    ndn_pkg::meta_t      meta_q;
    ndn_pkg::name_t      name_q;
    ndn_pkg::name_t      match_q;

    ndn_pkg::name_t hash_masked;

    // Hash round for the current length
    fib_name_hash probe_hash_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (state == fib_pkg::LPM_HASH),
        .in_name    (name_q),
        .in_len     (cur_len),
        .out_valid  (),
        .out_masked (hash_masked),
        .out_len    (probe_len),
        .out_index  (probe_index)
    );

    assign lookup_ready = state == fib_pkg::LPM_IDLE;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= fib_pkg::LPM_IDLE;
            cur_len <= '0;
        end else begin
            case (state)
                fib_pkg::LPM_IDLE: begin
                    if (lookup_valid) begin
                        cur_len <= lookup_meta.len;
                        // Zero length asks for no route at all
                        state <= (lookup_meta.len == '0) ? fib_pkg::LPM_DONE : fib_pkg::LPM_HASH;
                    end
                end
                fib_pkg::LPM_HASH: begin
                    state <= fib_pkg::LPM_PROBE;
                end
                fib_pkg::LPM_PROBE: begin
                    if (probe_hit) begin
                        state <= fib_pkg::LPM_DONE;
                    end else if (cur_len == ndn_pkg::len_t'(1)) begin
                        // Next length would be 0, so this is a miss
                        state <= fib_pkg::LPM_DONE;
                    end else begin
                        cur_len <= cur_len - 1'b1;
                        state   <= fib_pkg::LPM_HASH;
                    end
                end
                default: begin
                    if (tx.ready) begin
                        state <= fib_pkg::LPM_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_ready && lookup_valid) begin
            meta_q  <= lookup_meta;
            name_q  <= lookup_name;
            match_q <= '0;
        end
        // Masked name of the probed length on a hit
        if (state == fib_pkg::LPM_PROBE && probe_hit) begin
            match_q <= hash_masked;
        end
    end

    // Result held steady through LPM_DONE
    assign tx.valid = state == fib_pkg::LPM_DONE;
    assign tx.meta  = meta_q;
    assign tx.name  = name_q;
    assign tx.match = match_q;

endmodule

/* fib_spi_tx.sv */
`timescale 1ns/10ps
`include "fib_defs.svh"

module fib_spi_tx (
    input  logic       clk,
    input  logic       rst,
    fib_tx_if.tx       rx,
    output logic       spi_tx_valid,
    output logic [7:0] spi_tx_data,
    input  logic       spi_credit
);

    localparam int CNT_BITS = $clog2(`FIB_NAME_BYTES);
    localparam logic [CNT_BITS-1:0] LAST_BYTE = CNT_BITS'(`FIB_NAME_BYTES - 1);
    localparam int CREDIT_BITS = $clog2(`FIB_SPI_CREDITS + 1) + 1;

    logic                   busy;
    fib_pkg::tx_seg_e       seg;
    logic [CNT_BITS-1:0]    byte_cnt;
    logic [CREDIT_BITS-1:0] credit_cnt;
    logic                   send;
    ndn_pkg::meta_t         meta_q;
    ndn_pkg::name_t         name_sr;
    ndn_pkg::name_t         match_sr;

    assign rx.ready = !busy;

    // A byte leaves only while credit remains
    assign send         = busy && credit_cnt != '0;
    assign spi_tx_valid = send;

    always_comb begin
        case (seg)
            fib_pkg::SEG_META: spi_tx_data = meta_q;
            fib_pkg::SEG_NAME: spi_tx_data = name_sr[`FIB_NAME_BITS-1 -: 8];
            default:           spi_tx_data = match_sr[`FIB_NAME_BITS-1 -: 8];
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy       <= 1'b0;
            seg        <= fib_pkg::SEG_META;
            byte_cnt   <= '0;
            credit_cnt <= CREDIT_BITS'(`FIB_SPI_CREDITS);
        end else begin
            // Returned credit and spent byte may coincide
            credit_cnt <= credit_cnt + CREDIT_BITS'(spi_credit) - CREDIT_BITS'(send);
            if (rx.valid && !busy) begin
                busy     <= 1'b1;
                seg      <= fib_pkg::SEG_META;
                byte_cnt <= '0;
            end else if (send) begin
                case (seg)
                    fib_pkg::SEG_META: begin
                        seg <= fib_pkg::SEG_NAME;
                    end
                    fib_pkg::SEG_NAME: begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == LAST_BYTE) begin
                            seg <= fib_pkg::SEG_MATCH;
                        end
                    end
                    default: begin
                        byte_cnt <= byte_cnt + 1'b1;
                        // Last match byte frees the transmitter
                        if (byte_cnt == LAST_BYTE) begin
                            busy <= 1'b0;
                        end
                    end
                endcase
            end
        end
    end

    // Latch on accept, then shift out MSB first
    always_ff @(posedge clk) begin
        if (rx.valid && !busy) begin
            meta_q   <= rx.meta;
            name_sr  <= rx.name;
            match_sr <= rx.match;
        end else if (send && seg == fib_pkg::SEG_NAME) begin
            name_sr <= name_sr << 8;
        end else if (send && seg == fib_pkg::SEG_MATCH) begin
            match_sr <= match_sr << 8;
        end
    end

endmodule

/* fib_table.sv */
`timescale 1ns/10ps
`include "fib_defs.svh"

module fib_table (
    input  logic                       clk,
    input  logic                       rst,
    // Route configuration
    input  logic                       route_wr,
    input  logic                       route_remove,
    input  logic [`FIB_LEN_BITS-1:0]   route_len,
    input  logic [`FIB_NAME_BITS-1:0]  route_name,
    // Outgoing interest from the PIT
    input  logic                       lookup_valid,
    input  logic [7:0]                 lookup_meta,
    input  logic [`FIB_NAME_BITS-1:0]  lookup_name,
    output logic                       lookup_ready,
    // SPI receive bytes
    input  logic                       rx_valid,
    input  logic [7:0]                 rx_data,
    // Parsed interest toward the PIT
    output logic                       pit_req_valid,
    output logic [7:0]                 pit_req_meta,
    output logic [`FIB_NAME_BITS-1:0]  pit_req_name,
    // SPI transmit stream
    output logic                       spi_tx_valid,
    output logic [7:0]                 spi_tx_data,
    input  logic                       spi_credit
);

    ndn_pkg::len_t  probe_len;
    fib_pkg::hash_t probe_index;
    logic           probe_hit;

    fib_tx_if tx_if ();

    fib_route_table route_table_i (
        .clk          (clk),
        .rst          (rst),
        .route_wr     (route_wr),
        .route_remove (route_remove),
        .route_len    (route_len),
        .route_name   (route_name),
        .probe_len    (probe_len),
        .probe_index  (probe_index),
        .probe_hit    (probe_hit)
    );

    fib_interest_rx interest_rx_i (
        .clk           (clk),
        .rst           (rst),
        .rx_valid      (rx_valid),
        .rx_data       (rx_data),
        .pit_req_valid (pit_req_valid),
        .pit_req_meta  (pit_req_meta),
        .pit_req_name  (pit_req_name)
    );

    fib_lpm_engine lpm_engine_i (
        .clk          (clk),
        .rst          (rst),
        .lookup_valid (lookup_valid),
        .lookup_meta  (lookup_meta),
        .lookup_name  (lookup_name),
        .lookup_ready (lookup_ready),
        .probe_len    (probe_len),
        .probe_index  (probe_index),
        .probe_hit    (probe_hit),
        .tx           (tx_if.engine)
    );

    fib_spi_tx spi_tx_i (
        .clk          (clk),
        .rst          (rst),
        .rx           (tx_if.tx),
        .spi_tx_valid (spi_tx_valid),
        .spi_tx_data  (spi_tx_data),
        .spi_credit   (spi_credit)
    );

endmodule

/* fib_table_assert.sv */
`timescale 1ns/10ps
`include "fib_defs.svh"

module fib_table_assert (
    input logic clk,
    input logic rst,
    input logic pit_req_valid,
    input logic spi_tx_valid,
    input logic spi_credit,
    input logic lookup_valid,
    input logic lookup_ready,
    input logic result_valid,
    input logic result_ready
);

    // Failures seen so far, summed into the testbench totals
    int fail_count = 0;

    // Credits left on the link, counted from the SPI pins alone
    int credit_left;
    // Lookup accepted and its result not yet taken by the transmitter
    logic pending;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credit_left <= `FIB_SPI_CREDITS;
            pending     <= 1'b0;
        end else begin
            credit_left <= credit_left + int'(spi_credit) - int'(spi_tx_valid);
            if (lookup_valid && lookup_ready) begin
                pending <= 1'b1;
            end else if (result_valid && result_ready) begin
                pending <= 1'b0;
            end
        end
    end

    // Every byte on the wire has a credit behind it
    credit_used: assert property (@(posedge clk) disable iff (rst)
        spi_tx_valid |-> credit_left > 0)
        else begin
            $error("SPI byte sent with no credit left");
            fail_count++;
        end

    // PIT request is a single-cycle pulse
    pit_pulse: assert property (@(posedge clk) disable iff (rst)
        pit_req_valid |=> !pit_req_valid)
        else begin
            $error("pit_req_valid held for more than one cycle");
            fail_count++;
        end

    // No new lookup while a result waits for the transmitter
    busy_engine: assert property (@(posedge clk) disable iff (rst)
        pending |-> !lookup_ready)
        else begin
            $error("lookup_ready high while a result is pending");
            fail_count++;
        end

    reset_values: assert property (@(posedge clk)
        rst |-> (!pit_req_valid && !spi_tx_valid && lookup_ready))
        else begin
            $error("outputs left their reset values during reset");
            fail_count++;
        end

endmodule

bind fib_table fib_table_assert assert_i (
    .clk           (clk),
    .rst           (rst),
    .pit_req_valid (pit_req_valid),
    .spi_tx_valid  (spi_tx_valid),
    .spi_credit    (spi_credit),
    .lookup_valid  (lookup_valid),
    .lookup_ready  (lookup_ready),
    .result_valid  (tx_if.valid),
    .result_ready  (tx_if.ready)
);

/* fib_table_tb.sv */
`timescale 1ns/10ps
`include "fib_defs.svh"

module fib_table_tb;

    localparam int RESET_CYCLES  = 4;
    localparam int LOOKUP_CYCLES = 300;
    localparam int RANDOM_ROUNDS = 16;
    localparam int STREAM_BYTES  = 2 * `FIB_NAME_BYTES + 1;
    // Worst case per test, summed
    localparam int TEST_CYCLES = RESET_CYCLES + LOOKUP_CYCLES + 100 + 3 * LOOKUP_CYCLES + 20
        + LOOKUP_CYCLES + STREAM_BYTES * 30 + RANDOM_ROUNDS * (LOOKUP_CYCLES + 10);
    localparam int WATCHDOG_NS = 2 * TEST_CYCLES * 20;

    logic clk = 1'b0;
    logic rst;
    logic route_wr;
    logic route_remove;
    logic [`FIB_LEN_BITS-1:0] route_len;
    logic [`FIB_NAME_BITS-1:0] route_name;
    logic lookup_valid;
    logic [7:0] lookup_meta;
    logic [`FIB_NAME_BITS-1:0] lookup_name;
    logic lookup_ready;
    logic rx_valid;
    logic [7:0] rx_data;
    logic pit_req_valid;
    logic [7:0] pit_req_meta;
    logic [`FIB_NAME_BITS-1:0] pit_req_name;
    logic spi_tx_valid;
    logic [7:0] spi_tx_data;
    logic spi_credit;

    // Observed outputs
    logic [7:0] tx_bytes [$];
    logic [7:0] pit_meta_q [$];
    logic [`FIB_NAME_BITS-1:0] pit_name_q [$];

    // Credit bookkeeping
    logic auto_credit;
    int auto_seen = 0;
    int credit_request;
    int credits_given = 0;

    // Reference route banks
    bit model_bank [1 << `FIB_LEN_BITS][1 << `FIB_HASH_BITS];

    int checks;
    int errors;

    always #10 clk = ~clk;

    fib_table dut_i (
        .clk           (clk),
        .rst           (rst),
        .route_wr      (route_wr),
        .route_remove  (route_remove),
        .route_len     (route_len),
        .route_name    (route_name),
        .lookup_valid  (lookup_valid),
        .lookup_meta   (lookup_meta),
        .lookup_name   (lookup_name),
        .lookup_ready  (lookup_ready),
        .rx_valid      (rx_valid),
        .rx_data       (rx_data),
        .pit_req_valid (pit_req_valid),
        .pit_req_meta  (pit_req_meta),
        .pit_req_name  (pit_req_name),
        .spi_tx_valid  (spi_tx_valid),
        .spi_tx_data   (spi_tx_data),
        .spi_credit    (spi_credit)
    );

    // Collect SPI bytes and PIT requests
    always @(posedge clk) begin
        if (spi_tx_valid) begin
            tx_bytes.push_back(spi_tx_data);
            if (auto_credit) begin
                auto_seen++;
            end
        end
        if (pit_req_valid) begin
            pit_meta_q.push_back(pit_req_meta);
            pit_name_q.push_back(pit_req_name);
        end
    end

    // Credit returns with random gaps, one pulse per owed credit
    initial begin
        spi_credit = 1'b0;
        forever begin
            @(negedge clk);
            if (credits_given < credit_request + auto_seen && $urandom_range(0, 3) != 0) begin
                spi_credit = 1'b1;
                credits_given++;
            end else begin
                spi_credit = 1'b0;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t, the tests did not finish in time", $time);
        $display("Test failures found");
        $finish;
    end

    // Top len bits kept, rest cleared
    function automatic ndn_pkg::name_t mask_name(input ndn_pkg::name_t name, input int len);
        ndn_pkg::name_t keep;
        keep = '0;
        for (int b = 0; b < len; b++) begin
            keep[`FIB_NAME_BITS-1-b] = 1'b1;
        end
        return name & keep;
    endfunction

    // XOR of 10-bit chunks from bit 0, top chunk zero-extended
    function automatic fib_pkg::hash_t fold_hash(input ndn_pkg::name_t masked);
        fib_pkg::hash_t idx;
        idx = '0;
        for (int c = 0; c < `FIB_NAME_BITS; c += `FIB_HASH_BITS) begin
            idx = idx ^ fib_pkg::hash_t'(masked >> c);
        end
        return idx;
    endfunction

    // Longest installed prefix from the requested length down to 1
    function automatic ndn_pkg::name_t model_match(input ndn_pkg::meta_t meta,
                                                   input ndn_pkg::name_t name);
        ndn_pkg::name_t m;
        for (int l = int'(meta.len); l > 0; l--) begin
            m = mask_name(name, l);
            if (model_bank[l][fold_hash(m)]) begin
                return m;
            end
        end
        return '0;
    endfunction

    function automatic ndn_pkg::meta_t make_meta(input int len);
        ndn_pkg::meta_t m;
        m.flags = 2'($urandom_range(0, 3));
        m.len = ndn_pkg::len_t'(len);
        return m;
    endfunction

    task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        checks++;
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic wait_bytes(input int target, input int limit, input string what);
        int n;
        n = 0;
        while (tx_bytes.size() < target && n < limit) begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (tx_bytes.size() >= target) else begin
            $display("timed out at %0t waiting for %s", $time, what);
            errors++;
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!lookup_ready && n < LOOKUP_CYCLES) begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (lookup_ready) else begin
            $display("timed out at %0t waiting for lookup_ready", $time);
            errors++;
        end
    endtask

    // Wait until every sent byte has had its credit returned
    task automatic settle_credits();
        int n;
        n = 0;
        while (credits_given != credit_request + auto_seen && n < LOOKUP_CYCLES) begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (credits_given == credit_request + auto_seen) else begin
            $display("credit returns did not catch up with sent bytes at %0t", $time);
            errors++;
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic write_route(input ndn_pkg::name_t name, input int len, input logic remove);
        @(negedge clk);
        route_wr = 1'b1;
        route_remove = remove;
        route_len = ndn_pkg::len_t'(len);
        route_name = name;
        @(negedge clk);
        route_wr = 1'b0;
        route_remove = 1'b0;
        // Length 0 never holds a route
        if (len != 0) begin
            model_bank[len][fold_hash(mask_name(name, len))] = !remove;
        end
    endtask

    task automatic start_lookup(input ndn_pkg::meta_t meta, input ndn_pkg::name_t name);
        wait_ready();
        lookup_valid = 1'b1;
        lookup_meta = meta;
        lookup_name = name;
        @(negedge clk);
        lookup_valid = 1'b0;
        check_equal(64'(lookup_ready), 64'd0, "lookup_ready after accept");
    endtask

    // Metadata, name MSB first, then match MSB first
    task automatic check_stream(input int base, input ndn_pkg::meta_t meta,
                                input ndn_pkg::name_t name, input ndn_pkg::name_t match);
        logic [7:0] exp [STREAM_BYTES];
        exp[0] = meta;
        for (int i = 0; i < `FIB_NAME_BYTES; i++) begin
            exp[1 + i] = name[`FIB_NAME_BITS-1 - 8*i -: 8];
            exp[1 + `FIB_NAME_BYTES + i] = match[`FIB_NAME_BITS-1 - 8*i -: 8];
        end
        if (tx_bytes.size() >= base + STREAM_BYTES) begin
            for (int i = 0; i < STREAM_BYTES; i++) begin
                check_equal(64'(tx_bytes[base + i]), 64'(exp[i]),
                            $sformatf("stream byte %0d", i));
            end
        end
    endtask

    task automatic run_lookup(input ndn_pkg::meta_t meta, input ndn_pkg::name_t name,
                              input ndn_pkg::name_t match);
        int base;
        base = tx_bytes.size();
        start_lookup(meta, name);
        wait_bytes(base + STREAM_BYTES, LOOKUP_CYCLES, "the interest stream");
        check_stream(base, meta, name, match);
    endtask

    // Nine bytes, optionally with idle gaps between them
    task automatic send_interest(input ndn_pkg::meta_t meta, input ndn_pkg::name_t name,
                                 input bit gaps);
        logic [7:0] b;
        for (int i = 0; i <= `FIB_NAME_BYTES; i++) begin
            if (i == 0) begin
                b = meta;
            end else begin
                b = name[`FIB_NAME_BITS + 7 - 8*i -: 8];
            end
            if (gaps) begin
                repeat ($urandom_range(0, 2)) begin
                    @(negedge clk);
                    rx_valid = 1'b0;
                end
            end
            @(negedge clk);
            rx_valid = 1'b1;
            rx_data = b;
        end
    endtask

    task automatic stop_rx();
        @(negedge clk);
        rx_valid = 1'b0;
    endtask

    task automatic test_reset_state();
        ndn_pkg::name_t name;
        check_equal(64'(pit_req_valid), 64'd0, "pit_req_valid after reset");
        check_equal(64'(spi_tx_valid), 64'd0, "spi_tx_valid after reset");
        check_equal(64'(lookup_ready), 64'd1, "lookup_ready after reset");
        name = {$urandom, $urandom};
        // Empty table, all match bytes zero
        run_lookup(make_meta($urandom_range(1, 63)), name, '0);
    endtask

    task automatic test_interest_rx();
        ndn_pkg::meta_t meta [2];
        ndn_pkg::name_t name [2];
        int first;
        for (int k = 0; k < 2; k++) begin
            meta[k] = make_meta($urandom_range(0, 63));
            name[k] = {$urandom, $urandom};
        end
        first = pit_name_q.size();
        send_interest(meta[0], name[0], 1'b1);
        stop_rx();
        @(negedge clk);
        check_equal(64'(pit_name_q.size() - first), 64'd1, "PIT pulses for one packet");
        if (pit_name_q.size() > first) begin
            check_equal(64'(pit_meta_q[first]), 64'(meta[0]), "PIT metadata");
            check_equal(pit_name_q[first], name[0], "PIT name");
        end
        // Two packets with no idle cycle between them
        first = pit_name_q.size();
        send_interest(meta[1], name[1], 1'b0);
        send_interest(meta[0], name[0], 1'b0);
        stop_rx();
        @(negedge clk);
        check_equal(64'(pit_name_q.size() - first), 64'd2, "PIT pulses for two packets");
        if (pit_name_q.size() > first + 1) begin
            check_equal(pit_name_q[first], name[1], "first back-to-back name");
            check_equal(64'(pit_meta_q[first + 1]), 64'(meta[0]), "second back-to-back meta");
            check_equal(pit_name_q[first + 1], name[0], "second back-to-back name");
        end
        repeat (3) @(negedge clk);
        check_equal(pit_req_name, name[0], "held PIT name");
    endtask

    task automatic test_longest_match();
        ndn_pkg::name_t name;
        name = {$urandom, $urandom};
        write_route(name, 16, 1'b0);
        write_route(name, 24, 1'b0);
        write_route(name, 40, 1'b0);
        repeat (3) @(negedge clk);
        run_lookup(make_meta(48), name, mask_name(name, 40));
        write_route(name, 40, 1'b1);
        repeat (3) @(negedge clk);
        run_lookup(make_meta(48), name, mask_name(name, 24));
        run_lookup(make_meta(20), name, mask_name(name, 16));
    endtask

    task automatic test_credit_flow();
        ndn_pkg::name_t name;
        ndn_pkg::meta_t meta;
        int base;
        name = {$urandom, $urandom};
        meta = make_meta($urandom_range(0, 63));
        settle_credits();
        auto_credit = 1'b0;
        base = tx_bytes.size();
        start_lookup(meta, name);
        wait_bytes(base + `FIB_SPI_CREDITS, LOOKUP_CYCLES, "bytes of the reset credits");
        repeat (20) @(negedge clk);
        check_equal(64'(tx_bytes.size() - base), 64'(`FIB_SPI_CREDITS), "bytes with no credit back");
        // Each returned credit lets exactly one byte out
        for (int k = `FIB_SPI_CREDITS; k < STREAM_BYTES; k++) begin
            credit_request++;
            wait_bytes(base + k + 1, 30, "a byte released by a credit");
            repeat (3) @(negedge clk);
            check_equal(64'(tx_bytes.size() - base), 64'(k + 1), "bytes after a credit pulse");
        end
        check_stream(base, meta, name, model_match(meta, name));
        // Refill to the reset credit count
        credit_request += `FIB_SPI_CREDITS;
        settle_credits();
        auto_credit = 1'b1;
    endtask

    task automatic test_random_lookups();
        ndn_pkg::name_t pool [RANDOM_ROUNDS];
        ndn_pkg::name_t name;
        ndn_pkg::meta_t meta;
        int pick;
        for (int r = 0; r < RANDOM_ROUNDS; r++) begin
            pool[r] = {$urandom, $urandom};
            write_route(pool[r], $urandom_range(0, 63), 1'b0);
            pick = $urandom_range(0, r);
            write_route(pool[pick], $urandom_range(0, 63), $urandom_range(0, 3) == 0);
            repeat (3) @(negedge clk);
            // Shared upper half gives hits on short prefixes
            pick = $urandom_range(0, r);
            name = {pool[pick][63:32], 32'($urandom)};
            meta = make_meta($urandom_range(0, 63));
            run_lookup(meta, name, model_match(meta, name));
        end
    endtask

    initial begin
        void'($urandom(32'h51ae9f99));
        rst = 1'b1;
        route_wr = 1'b0;
        route_remove = 1'b0;
        route_len = '0;
        route_name = '0;
        lookup_valid = 1'b0;
        lookup_meta = '0;
        lookup_name = '0;
        rx_valid = 1'b0;
        rx_data = '0;
        auto_credit = 1'b1;
        credit_request = 0;
        checks = 0;
        errors = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        test_interest_rx();
        test_longest_match();
        test_credit_flow();
        test_random_lookups();
        settle_credits();
        $display("%0d checks, %0d errors, %0d assertion failures",
                 checks, errors, dut_i.assert_i.fail_count);
        if (errors + dut_i.assert_i.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+.
ndn_pkg.sv
fib_pkg.sv
fib_tx_if.sv
fib_name_hash.sv
fib_route_table.sv
fib_interest_rx.sv
fib_lpm_engine.sv
fib_spi_tx.sv
fib_table.sv
fib_table_assert.sv
fib_table_tb.sv

/* Makefile */
TOP = fib_table_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f all.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed!"

clean:
	rm -rf obj_dir
